// ==== Makefile ====
TOP := cbr_tile_ctrl_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f cbr_tile_ctrl.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f cbr_tile_ctrl.f

clean:
	rm -rf obj_dir sim.log

// ==== bench/cbr_tile_ctrl_properties.sv ====
`timescale 1ns/1ps

module cbr_tile_ctrl_properties (
  input logic                       clk,
  input logic                       reset,
  input cbr_signal_pkg::strobe_t    sa_ctrl,
  input cbr_signal_pkg::strobe_t    channel_out,
  input cbr_signal_pkg::strobe_t    sum_recv,
  input cbr_timing_pkg::row_idx_t   out_row_idx,
  input cbr_signal_pkg::post_ctrl_t post,
  input logic                       conv_fifo_end
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  ////////////////////////////////////////
  // clear strobes
  ////////////////////////////////////////

  // each clear is one cycle wide
  sa_clear_pulse: assert property (@(posedge clk) disable iff (reset)
    sa_ctrl.reset |=> !sa_ctrl.reset)
    else begin
      fail_count++;
      $error("array clear held for more than one cycle");
    end

  channel_clear_pulse: assert property (@(posedge clk) disable iff (reset)
    channel_out.reset |=> !channel_out.reset)
    else begin
      fail_count++;
      $error("channel out clear held for more than one cycle");
    end

  sum_clear_pulse: assert property (@(posedge clk) disable iff (reset)
    sum_recv.reset |=> !sum_recv.reset)
    else begin
      fail_count++;
      $error("sum receiver clear held for more than one cycle");
    end

  bias_clear_pulse: assert property (@(posedge clk) disable iff (reset)
    post.bias.reset |=> !post.bias.reset)
    else begin
      fail_count++;
      $error("bias clear held for more than one cycle");
    end

  relu_clear_pulse: assert property (@(posedge clk) disable iff (reset)
    post.relu.reset |=> !post.relu.reset)
    else begin
      fail_count++;
      $error("relu clear held for more than one cycle");
    end

  ////////////////////////////////////////
  // windows
  ////////////////////////////////////////

  // sum receive always carries a row
  row_idx_nonzero: assert property (@(posedge clk) disable iff (reset)
    sum_recv.en |-> (out_row_idx != '0))
    else begin
      fail_count++;
      $error("sum receive active with row index zero");
    end

  // end pulse sits on the last FIFO enable cycle
  fifo_end_inside: assert property (@(posedge clk) disable iff (reset)
    conv_fifo_end |-> post.conv_fifo_en)
    else begin
      fail_count++;
      $error("conv FIFO end outside the FIFO enable window");
    end

  fifo_end_last: assert property (@(posedge clk) disable iff (reset)
    conv_fifo_end |=> !post.conv_fifo_en)
    else begin
      fail_count++;
      $error("conv FIFO enable continues after the end pulse");
    end

endmodule

bind cbr_tile_ctrl cbr_tile_ctrl_properties u_cbr_tile_ctrl_properties (.*);

// ==== bench/cbr_tile_ctrl_tb.sv ====
`timescale 1ns/1ps

module cbr_tile_ctrl_tb;
  import cbr_timing_pkg::*;
  import cbr_signal_pkg::*;

  // one row per reset since mode and length are only sampled then
  typedef struct packed {
    mode_t     mode;
    tile_len_t len;
    int        min_gap;
    int        jitter;
    int        tiles;
  } row_t;

  // every output the model predicts for one cycle
  typedef struct packed {
    strobe_t    sa;
    strobe_t    co;
    strobe_t    sr;
    row_idx_t   idx;
    post_ctrl_t post;
    logic       mam;
    logic       fend;
  } obs_t;

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  localparam int ROW_COUNT = 5;
  // min gap N + 2 + 34 puts the next start on E+34
  // jitter 0 rows run back to back at exactly that gap
  localparam row_t ROWS [ROW_COUNT] = '{
    '{mode: 4'd1, len: 16'd1,    min_gap: 37,   jitter: 5, tiles: 3},
    '{mode: 4'd1, len: 16'd4,    min_gap: 40,   jitter: 0, tiles: 3},
    '{mode: 4'd0, len: 16'd23,   min_gap: 59,   jitter: 0, tiles: 2},
    '{mode: 4'd2, len: 16'd200,  min_gap: 236,  jitter: 5, tiles: 2},
    '{mode: 4'd1, len: 16'd1500, min_gap: 1536, jitter: 0, tiles: 2}
  };

  logic       clk;
  logic       reset;
  logic       re_fm_en;
  mode_t      mode_init;
  tile_len_t  tile_len_init;
  strobe_t    sa_ctrl;
  strobe_t    channel_out;
  strobe_t    sum_recv;
  row_idx_t   out_row_idx;
  post_ctrl_t post;
  logic       mult_array_mode;
  logic       conv_fifo_end;

  // rising edges so far and thus the index of the current cycle
  int    cyc = 0;
  // recorded start cycles T since the last reset
  int    starts[$];
  int    ends_seen;
  int    cur_n;
  mode_t cur_mode;
  logic  check_on;

  cbr_tile_ctrl u_cbr_tile_ctrl (
    .clk             (clk),
    .reset           (reset),
    .re_fm_en        (re_fm_en),
    .mode_init       (mode_init),
    .tile_len_init   (tile_len_init),
    .sa_ctrl         (sa_ctrl),
    .channel_out     (channel_out),
    .sum_recv        (sum_recv),
    .out_row_idx     (out_row_idx),
    .post            (post),
    .mult_array_mode (mult_array_mode),
    .conv_fifo_end   (conv_fifo_end)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////
  // cycle model
  ////////////////////////////////////////

  // outputs caused by one tile started in cycle t
  function automatic obs_t tile_expect(input int t, input int c);
    obs_t o;
    int   k;
    o = '0;
    // k counts from E = T + N + 2
    k = c - (t + cur_n + 2);
    o.sa.en             = (c >= t) && (k <= 30);
    o.sa.reset          = (k == 31);
    o.co.reset          = (k == 0);
    o.co.en             = (k >= 16) && (k <= 31);
    o.sr.en             = (k >= 17) && (k <= 32);
    o.sr.reset          = (k == 33);
    // row 1 in E+17 up to row 16 in E+32
    if (o.sr.en) begin
      o.idx = row_idx_t'(k - 16);
    end
    o.post.mult_e_en    = (k >= 18) && (k <= 33);
    o.post.bias.en      = (k >= 19) && (k <= 34);
    o.post.bias.reset   = (k == 35);
    o.post.relu.en      = (k >= 20) && (k <= 35);
    o.post.relu.reset   = (k == 36);
    o.post.conv_fifo_en = (k >= 21) && (k <= 36);
    o.mam               = (cur_mode == 4'd1) && o.post.mult_e_en;
    o.fend              = (k == 36);
    return o;
  endfunction

  // true once any bound assertion on the DUT has failed
  function automatic bit assertions_failed();
    return u_cbr_tile_ctrl.u_cbr_tile_ctrl_properties.fail_count != 0;
  endfunction

  task automatic stop_on_failure();
    $display("Regression failed");
    $fatal(1, "run stopped in cycle %0d", cyc);
  endtask

  task automatic compare_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%0h expected 0x%0h in cycle %0d", name, got, exp, cyc);
      stop_on_failure();
    end
  endtask

  // overlapping tiles never share a window so their outputs simply OR
  task automatic check_outputs();
    obs_t e;
    e = '0;
    foreach (starts[i]) begin
      e = obs_t'(e | tile_expect(starts[i], cyc));
    end
    compare_value("sa_ctrl.en", 16'(sa_ctrl.en), 16'(e.sa.en));
    compare_value("sa_ctrl.reset", 16'(sa_ctrl.reset), 16'(e.sa.reset));
    compare_value("channel_out.en", 16'(channel_out.en), 16'(e.co.en));
    compare_value("channel_out.reset", 16'(channel_out.reset), 16'(e.co.reset));
    compare_value("sum_recv.en", 16'(sum_recv.en), 16'(e.sr.en));
    compare_value("sum_recv.reset", 16'(sum_recv.reset), 16'(e.sr.reset));
    compare_value("out_row_idx", 16'(out_row_idx), 16'(e.idx));
    compare_value("post.mult_e_en", 16'(post.mult_e_en), 16'(e.post.mult_e_en));
    compare_value("post.bias.en", 16'(post.bias.en), 16'(e.post.bias.en));
    compare_value("post.bias.reset", 16'(post.bias.reset), 16'(e.post.bias.reset));
    compare_value("post.relu.en", 16'(post.relu.en), 16'(e.post.relu.en));
    compare_value("post.relu.reset", 16'(post.relu.reset), 16'(e.post.relu.reset));
    compare_value("post.conv_fifo_en", 16'(post.conv_fifo_en), 16'(e.post.conv_fifo_en));
    compare_value("mult_array_mode", 16'(mult_array_mode), 16'(e.mam));
    compare_value("conv_fifo_end", 16'(conv_fifo_end), 16'(e.fend));
  endtask

  // sample mid-cycle when inputs driven 2 ns after the edge have settled
  always @(negedge clk) begin
    if (assertions_failed()) begin
      $display("a bound assertion on the DUT failed before cycle %0d", cyc);
      stop_on_failure();
    end else if (check_on) begin
      check_outputs();
      if (conv_fifo_end) begin
        ends_seen = ends_seen + 1;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      next_cycle();
    end
  endtask

  // two edges with reset high latch mode and length
  task automatic apply_reset(input mode_t mode, input tile_len_t len);
    check_on      = 1'b0;
    reset         = 1'b1;
    mode_init     = mode;
    tile_len_init = len;
    cur_mode      = mode;
    cur_n         = int'(len);
    starts.delete();
    ends_seen     = 0;
    next_cycle();
    next_cycle();
    reset    = 1'b0;
    check_on = 1'b1;
  endtask

  task automatic start_tile();
    re_fm_en = 1'b1;
    starts.push_back(cyc);
    next_cycle();
    re_fm_en = 1'b0;
  endtask

  // wait for one conv_fifo_end per started tile
  // the last lands N + 38 cycles after its start
  task automatic wait_tile_ends(input tile_len_t len);
    int waited;
    int limit;
    waited = 0;
    limit  = int'(len) + 100;
    while (ends_seen < starts.size()) begin
      if (waited >= limit) begin
        $display("timed out after %0d cycles waiting for conv_fifo_end", waited);
        stop_on_failure();
      end else begin
        next_cycle();
        waited++;
      end
    end
  endtask

  initial begin
    int extra;
    reset         = 1'b1;
    re_fm_en      = 1'b0;
    mode_init     = '0;
    tile_len_init = '0;
    check_on      = 1'b0;
    ends_seen     = 0;
    cur_n         = 0;
    cur_mode      = '0;
    void'($urandom(32'hcffc_0c1b));
    for (int r = 0; r < ROW_COUNT; r++) begin
      apply_reset(ROWS[r].mode, ROWS[r].len);
      // quiet stretch where all outputs must stay low
      idle_cycles(3 + int'($urandom_range(4, 0)));
      for (int k = 0; k < ROWS[r].tiles; k++) begin
        start_tile();
        if (k < ROWS[r].tiles - 1) begin
          extra = int'($urandom_range(ROWS[r].jitter, 0));
          // start_tile already used one cycle of the gap
          idle_cycles(ROWS[r].min_gap + extra - 1);
        end
      end
      wait_tile_ends(ROWS[r].len);
      idle_cycles(4);
    end
    if (assertions_failed()) begin
      $display("a bound assertion on the DUT failed near the end of the run");
      stop_on_failure();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// ==== cbr_tile_ctrl.f ====
common/cbr_timing_pkg.sv
common/cbr_signal_pkg.sv
source/pixel_phase_counter.sv
channel_sequencer/channel_sequencer.sv
source/postproc_stage_chain.sv
source/cbr_tile_ctrl.sv
bench/cbr_tile_ctrl_properties.sv
bench/cbr_tile_ctrl_tb.sv

// ==== channel_sequencer/channel_sequencer.sv ====
`timescale 1ns/1ps

module channel_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     re_fm_en,
  input  logic                     pixel_done,
  output cbr_signal_pkg::strobe_t  sa_ctrl,
  output logic                     channel_out_en,
  output cbr_timing_pkg::row_idx_t out_row_idx,
  output cbr_signal_pkg::strobe_t  sum_recv,
  output logic                     row_end
);
  import cbr_timing_pkg::*;

  // row counter running flag, set after cycle E
  logic     row_busy;
  // counter advances this cycle
  logic     row_step;
  // last row count, counter wraps
  logic     row_wrap;
  row_cnt_t row_cnt;

  // array enable, held part
  logic     sa_en_q;
  // array clear pulse
  logic     sa_clr_q;
  // sum receiver window and clear
  logic     sum_en_q;
  logic     sum_clr_q;
  // row index, one cycle behind channel out
  row_idx_t row_idx_q;

  ////////////////////////////////////////
  // output-row counter
  ////////////////////////////////////////

  // count 0 in cycle E, j in cycle E+j
  assign row_step = pixel_done | row_busy;
  assign row_wrap = row_step && (row_cnt == ROW_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      row_busy <= 1'b0;
    end else if (pixel_done) begin
      row_busy <= 1'b1;
    end else if (row_wrap) begin
      row_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      row_cnt <= '0;
    end else if (row_step) begin
      if (row_wrap) begin
        row_cnt <= '0;
      end else begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // systolic array strobes
  ////////////////////////////////////////

  // enable opens on the start pulse and holds through the pixel phase
  always_ff @(posedge clk) begin
    if (reset) begin
      sa_en_q <= 1'b0;
    end else if (re_fm_en) begin
      sa_en_q <= 1'b1;
    end else if (row_step && (row_cnt == SA_STOP)) begin
      sa_en_q <= 1'b0;
    end
  end

  // single clear right after the enable drops
  always_ff @(posedge clk) begin
    if (reset) begin
      sa_clr_q <= 1'b0;
    end else begin
      sa_clr_q <= row_step && (row_cnt == SA_STOP);
    end
  end

  // start cycle already enables the array
  assign sa_ctrl = '{en: sa_en_q | re_fm_en, reset: sa_clr_q};

  ////////////////////////////////////////
  // channel out and sum receiver
  ////////////////////////////////////////

  // channel out, 16 rows starting E+16
  always_ff @(posedge clk) begin
    if (reset) begin
      channel_out_en <= 1'b0;
    end else if (row_step && (row_cnt == OUT_START)) begin
      channel_out_en <= 1'b1;
    end else if (row_step && (row_cnt == OUT_ROWS - 1'b1)) begin
      channel_out_en <= 1'b0;
    end
  end

  // sum receive trails channel out by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_en_q <= 1'b0;
    end else if (row_step && (row_cnt == OUT_START + 1'b1)) begin
      sum_en_q <= 1'b1;
    end else if (row_step && (row_cnt == OUT_ROWS)) begin
      sum_en_q <= 1'b0;
    end
  end

  // row index 1..16 in step with sum receive, zero elsewhere
  always_ff @(posedge clk) begin
    if (reset) begin
      row_idx_q <= '0;
    end else if (row_step && (row_cnt > OUT_START) && (row_cnt < OUT_ROWS)) begin
      row_idx_q <= row_idx_t'(row_cnt - OUT_START);
    end else begin
      row_idx_q <= '0;
    end
  end

  assign out_row_idx = row_idx_q;

  // last received row, drives the post-processing end chain
  assign row_end = row_step && (row_cnt == OUT_ROWS);

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_clr_q <= 1'b0;
    end else begin
      sum_clr_q <= row_end;
    end
  end

  assign sum_recv = '{en: sum_en_q, reset: sum_clr_q};

endmodule

// ==== common/cbr_signal_pkg.sv ====
package cbr_signal_pkg;

  ////////////////////////////////////////
  // strobe pair
  ////////////////////////////////////////

  // enable window plus one-cycle clear
  // used by the array, channel out, sum receiver
  // and every post-processing stage
  typedef struct packed {
    logic en;
    logic reset;
  } strobe_t;

  ////////////////////////////////////////
  // post-processing group
  ////////////////////////////////////////

  // one field per stage, in pipeline order
  // multiply-by-E has no clear of its own on the outside
  typedef struct packed {
    // sum * E multiplier enable
    logic    mult_e_en;
    // bias adder
    strobe_t bias;
    // relu and requant scale
    strobe_t relu;
    // write enable of the conv FIFO
    logic    conv_fifo_en;
  } post_ctrl_t;

endpackage

// ==== common/cbr_timing_pkg.sv ====
package cbr_timing_pkg;

  ////////////////////////////////////////
  // counter widths
  ////////////////////////////////////////

  // tile length in input words, nif * k * k
  localparam int TILE_LEN_W = 16;
  // pixel counter runs past the tile length by the alignment cycles
  localparam int PIX_CNT_W = TILE_LEN_W + 1;
  // output-row counter and row index
  localparam int ROW_CNT_W = 6;
  // kernel mode word
  localparam int MODE_W = 4;

  typedef logic [TILE_LEN_W-1:0] tile_len_t;
  typedef logic [PIX_CNT_W-1:0]  pix_cnt_t;
  typedef logic [ROW_CNT_W-1:0]  row_cnt_t;
  typedef logic [ROW_CNT_W-1:0]  row_idx_t;
  typedef logic [MODE_W-1:0]     mode_t;

  ////////////////////////////////////////
  // pixel phase
  ////////////////////////////////////////

  // words between last pixel and array input
  localparam pix_cnt_t PIXEL_ALIGN = pix_cnt_t'(2);

  ////////////////////////////////////////
  // channel phase offsets (row counts)
  ////////////////////////////////////////

  // rows of the systolic array
  localparam row_cnt_t OUT_ROWS  = row_cnt_t'(32);
  // channel output window opens one row after this
  localparam row_cnt_t OUT_START = row_cnt_t'(15);
  // array stops here, clear follows next cycle
  localparam row_cnt_t SA_STOP   = row_cnt_t'(30);
  // last count before the counter wraps
  localparam row_cnt_t ROW_LAST  = row_cnt_t'(33);

  // mode value that turns on the multiplier array
  localparam mode_t MODE_MULT = mode_t'(1);

endpackage

// ==== source/cbr_tile_ctrl.sv ====
`timescale 1ns/1ps

module cbr_tile_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       re_fm_en,
  input  cbr_timing_pkg::mode_t      mode_init,
  input  cbr_timing_pkg::tile_len_t  tile_len_init,
  output cbr_signal_pkg::strobe_t    sa_ctrl,
  output cbr_signal_pkg::strobe_t    channel_out,
  output cbr_signal_pkg::strobe_t    sum_recv,
  output cbr_timing_pkg::row_idx_t   out_row_idx,
  output cbr_signal_pkg::post_ctrl_t post,
  output logic                       mult_array_mode,
  output logic                       conv_fifo_end
);

  // pixel phase end, cycle E
  logic pixel_done;
  // channel out halves come from two blocks
  logic channel_out_en;
  logic channel_out_reset;
  // last received row
  logic row_end;

  ////////////////////////////////////////
  // pixel phase
  ////////////////////////////////////////

  pixel_phase_counter u_pixel_phase_counter (
    .clk               (clk),
    .reset             (reset),
    .re_fm_en          (re_fm_en),
    .tile_len_init     (tile_len_init),
    .pixel_done        (pixel_done),
    .channel_out_reset (channel_out_reset)
  );

  ////////////////////////////////////////
  // channel phase
  ////////////////////////////////////////

  channel_sequencer u_channel_sequencer (
    .clk            (clk),
    .reset          (reset),
    .re_fm_en       (re_fm_en),
    .pixel_done     (pixel_done),
    .sa_ctrl        (sa_ctrl),
    .channel_out_en (channel_out_en),
    .out_row_idx    (out_row_idx),
    .sum_recv       (sum_recv),
    .row_end        (row_end)
  );

  assign channel_out = '{en: channel_out_en, reset: channel_out_reset};

  // post-processing stages behind the sum receiver
  postproc_stage_chain u_postproc_stage_chain (
    .clk             (clk),
    .reset           (reset),
    .mode_init       (mode_init),
    .sum_recv        (sum_recv),
    .row_end         (row_end),
    .post            (post),
    .mult_array_mode (mult_array_mode),
    .conv_fifo_end   (conv_fifo_end)
  );

endmodule

// ==== source/pixel_phase_counter.sv ====
`timescale 1ns/1ps

module pixel_phase_counter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      re_fm_en,
  input  cbr_timing_pkg::tile_len_t tile_len_init,
  output logic                      pixel_done,
  output logic                      channel_out_reset
);
  import cbr_timing_pkg::*;

  // tile length, captured while reset is high
  tile_len_t tile_len;
  // last count of the pixel phase
  pix_cnt_t  pix_last;
  // running word count
  pix_cnt_t  pix_cnt;
  // phase active after the start cycle
  logic      busy;
  // counter advances this cycle
  logic      counting;

  ////////////////////////////////////////
  // tile length
  ////////////////////////////////////////

  // only loaded during reset, held afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      tile_len <= tile_len_init;
    end
  end

  // N words plus alignment into the array
  assign pix_last = pix_cnt_t'(tile_len) + PIXEL_ALIGN;

  ////////////////////////////////////////
  // word counter
  ////////////////////////////////////////

  // start cycle counts too, so count == k in cycle T+k
  assign counting   = re_fm_en | busy;
  // combinational end marker in cycle E
  assign pixel_done = counting && (pix_cnt == pix_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (pixel_done) begin
      busy <= 1'b0;
    end else if (re_fm_en) begin
      busy <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
    end else if (counting) begin
      // wrap to zero for the next tile
      if (pixel_done) begin
        pix_cnt <= '0;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // channel-out clear lands in cycle E
  // decoded one count early, then registered
  always_ff @(posedge clk) begin
    if (reset) begin
      channel_out_reset <= 1'b0;
    end else begin
      channel_out_reset <= counting && ((pix_cnt + 1'b1) == pix_last);
    end
  end

endmodule

// ==== source/postproc_stage_chain.sv ====
`timescale 1ns/1ps

module postproc_stage_chain (
  input  logic                       clk,
  input  logic                       reset,
  input  cbr_timing_pkg::mode_t      mode_init,
  input  cbr_signal_pkg::strobe_t    sum_recv,
  input  logic                       row_end,
  output cbr_signal_pkg::post_ctrl_t post,
  output logic                       mult_array_mode,
  output logic                       conv_fifo_end
);
  import cbr_timing_pkg::*;
  import cbr_signal_pkg::*;

  // kernel mode, captured while reset is high
  mode_t      mode;

  // one strobe pair per stage
  strobe_t    mult_e_q;
  strobe_t    bias_q;
  strobe_t    relu_q;
  logic       fifo_en_q;

  // end pulse, one tap per stage, last tap is the FIFO end
  logic [3:0] end_q;
  logic       mult_mode_q;

  ////////////////////////////////////////
  // mode
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mode <= mode_init;
    end
  end

  ////////////////////////////////////////
  // stage pipeline
  ////////////////////////////////////////

  // sum recv -> mult E -> bias -> relu/scale -> conv FIFO
  always_ff @(posedge clk) begin
    if (reset) begin
      mult_e_q  <= '0;
      bias_q    <= '0;
      relu_q    <= '0;
      fifo_en_q <= 1'b0;
    end else begin
      mult_e_q  <= sum_recv;
      bias_q    <= mult_e_q;
      relu_q    <= bias_q;
      // FIFO only takes the enable
      fifo_en_q <= relu_q.en;
    end
  end

  // end marker runs alongside, E+33 .. E+36
  always_ff @(posedge clk) begin
    if (reset) begin
      end_q <= '0;
    end else begin
      end_q <= {end_q[2:0], row_end};
    end
  end

  // multiplier array follows the mult E window in mode 1 only
  always_ff @(posedge clk) begin
    if (reset) begin
      mult_mode_q <= 1'b0;
    end else begin
      mult_mode_q <= (mode == MODE_MULT) && sum_recv.en;
    end
  end

  assign post = '{
    mult_e_en:    mult_e_q.en,
    bias:         bias_q,
    relu:         relu_q,
    conv_fifo_en: fifo_en_q
  };

  assign mult_array_mode = mult_mode_q;
  assign conv_fifo_end   = end_q[3];

endmodule
